/* source/rv_core_pkg.sv */
package rv_core_pkg;

    localparam int xlen       = 64;
    localparam int reg_addr_w = 5;
    localparam int imm_w      = 32;
    localparam int wmask_w    = xlen / 8;

    // how a result lands in the register file
    typedef enum logic [1:0] {
        ext_full   = 2'd0, // ld, link, 64-bit alu
        ext_word_s = 2'd1, // lw, addw, divw
        ext_word_z = 2'd2, // lwu
        ext_half_s = 2'd3  // lh
    } ext_kind_e;

    typedef enum logic {
        src_ex  = 1'b0,
        src_mem = 1'b1
    } src_sel_e;

    // one retiring instruction
    typedef struct packed {
        logic [reg_addr_w-1:0] rd;
        logic                  wen;
        logic                  is_store;
        logic                  is_ebreak;
        src_sel_e              src_sel;
        ext_kind_e             ext_kind;
        logic [xlen-1:0]       ex_res;
        logic [xlen-1:0]       mem_res;
        logic [reg_addr_w-1:0] rs1;     // store base
        logic [imm_w-1:0]      imm;     // already sign-extended by decode
        logic [wmask_w-1:0]    wmask;
    } commit_req_t;

endpackage

/* source/axil_pkg.sv */
package axil_pkg;

    localparam int axil_addr_w = 32;
    localparam int axil_data_w = 64;
    localparam int axil_strb_w = axil_data_w / 8;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    localparam logic [2:0] prot_data = 3'b000; // unprivileged, secure, data

    typedef struct packed {
        logic [axil_addr_w-1:0] awaddr;
        logic [2:0]             awprot;
    } axil_aw_t;

    typedef struct packed {
        logic [axil_data_w-1:0] wdata;
        logic [axil_strb_w-1:0] wstrb;
    } axil_w_t;

    typedef struct packed {
        logic [1:0] bresp;
    } axil_b_t;

endpackage

/* source/wb_result_format.sv */
`timescale 1ns/1ns

module wb_result_format (
    input  rv_core_pkg::commit_req_t     res_in,
    output logic [rv_core_pkg::xlen-1:0] wdata
);

    localparam int xl = rv_core_pkg::xlen;

    logic [xl-1:0] sel;

    assign sel = (res_in.src_sel == rv_core_pkg::src_mem) ? res_in.mem_res : res_in.ex_res;

    always_comb begin
        unique case (res_in.ext_kind)
            rv_core_pkg::ext_full: begin
                wdata = sel;
            end
            rv_core_pkg::ext_word_s: begin
                wdata = {{(xl - 32){sel[31]}}, sel[31:0]};
            end
            rv_core_pkg::ext_word_z: begin
                wdata = {{(xl - 32){1'b0}}, sel[31:0]};
            end
            rv_core_pkg::ext_half_s: begin
                wdata = {{(xl - 16){sel[15]}}, sel[15:0]};
            end
        endcase
    end

endmodule

/* source/gpr_file.sv */
`timescale 1ns/1ns

module gpr_file (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               wen,
    input  logic [rv_core_pkg::reg_addr_w-1:0] waddr,
    input  logic [rv_core_pkg::xlen-1:0]       wdata,
    input  logic [rv_core_pkg::reg_addr_w-1:0] raddr_a,
    output logic [rv_core_pkg::xlen-1:0]       rdata_a,
    input  logic [rv_core_pkg::reg_addr_w-1:0] raddr_b,
    output logic [rv_core_pkg::xlen-1:0]       rdata_b
);

    localparam int depth = 2 ** rv_core_pkg::reg_addr_w;

    logic [rv_core_pkg::xlen-1:0] regs [depth];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin // x0 is read only
            regs[waddr] <= wdata;
        end
    end

    // entry zero is never written, so both ports see zero there
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    x0_reads_zero_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        raddr_a == '0 |-> rdata_a == '0
    );

    x0_reads_zero_b: assert property (
        @(posedge clk) disable iff (!rst_n)
        raddr_b == '0 |-> rdata_b == '0
    );

endmodule

/* source/store_axil_master.sv */
`timescale 1ns/1ns

module store_axil_master (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                store_start,
    input  logic [axil_pkg::axil_addr_w-1:0]    store_addr,
    input  logic [axil_pkg::axil_data_w-1:0]    store_data,
    input  logic [axil_pkg::axil_strb_w-1:0]    store_strb,
    output logic                                aw_valid,
    output axil_pkg::axil_aw_t                  aw,
    input  logic                                aw_ready,
    output logic                                w_valid,
    output axil_pkg::axil_w_t                   w,
    input  logic                                w_ready,
    input  logic                                b_valid,
    input  axil_pkg::axil_b_t                   b,
    output logic                                b_ready,
    output logic                                store_done,
    output logic                                store_err,
    input  logic                                abort
);

    logic pending; // a write is in flight
    logic b_hs;

    // payload comes straight from the latched request, stable for the whole store
    assign aw = '{awaddr: store_addr, awprot: axil_pkg::prot_data};
    assign w  = '{wdata: store_data, wstrb: store_strb};

    // response only once both request channels are through
    assign b_ready = pending && !aw_valid && !w_valid;
    assign b_hs    = b_valid && b_ready;

    assign store_done = b_hs && (b.bresp == axil_pkg::resp_okay);
    assign store_err  = b_hs && (b.bresp != axil_pkg::resp_okay);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            pending  <= 1'b0;
        end else if (abort) begin // watchdog gave up
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            pending  <= 1'b0;
        end else if (store_start) begin
            aw_valid <= 1'b1;
            w_valid  <= 1'b1;
            pending  <= 1'b1;
        end else begin
            if (aw_valid && aw_ready) begin
                aw_valid <= 1'b0;
            end
            if (w_valid && w_ready) begin
                w_valid <= 1'b0;
            end
            if (b_hs) begin
                pending <= 1'b0;
            end
        end
    end

    aw_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        aw_valid && !aw_ready && !abort |=> aw_valid && $stable(aw)
    );

    w_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        w_valid && !w_ready && !abort |=> w_valid && $stable(w)
    );

endmodule

/* source/bus_watchdog.sv */
`timescale 1ns/1ns

module bus_watchdog #(
    parameter int TIMEOUT_CYCLES = 64
) (
    input  logic clk,
    input  logic rst_n,
    input  logic watch_en,
    output logic timeout
);

    localparam int cnt_w = $clog2(TIMEOUT_CYCLES + 1);

    logic [cnt_w-1:0] cnt;

    // cnt is k-1 in the k-th cycle after the store was accepted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!watch_en) begin
            cnt <= '0;
        end else if (cnt != cnt_w'(TIMEOUT_CYCLES)) begin
            cnt <= cnt + 1'b1; // parks at the limit, so only one pulse
        end
    end

    assign timeout = watch_en && (cnt == cnt_w'(TIMEOUT_CYCLES - 1));

    timeout_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        timeout |=> !timeout
    );

endmodule

/* source/commit_fsm.sv */
`timescale 1ns/1ns

module commit_fsm (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               commit_valid,
    input  rv_core_pkg::commit_req_t           commit,
    output logic                               commit_ready,
    input  logic [rv_core_pkg::xlen-1:0]       base_val,
    input  logic [rv_core_pkg::xlen-1:0]       fmt_wdata,
    output logic                               gpr_wen,
    output logic [rv_core_pkg::reg_addr_w-1:0] gpr_waddr,
    output logic [rv_core_pkg::xlen-1:0]       gpr_wdata,
    output logic                               store_start,
    output logic [axil_pkg::axil_addr_w-1:0]   store_addr,
    output logic [axil_pkg::axil_data_w-1:0]   store_data,
    output logic [axil_pkg::axil_strb_w-1:0]   store_strb,
    input  logic                               store_done,
    input  logic                               store_err,
    output logic                               watch_en,
    input  logic                               timeout,
    output logic                               abort,
    output logic                               halted,
    output logic                               bus_err
);

    typedef enum logic [1:0] {
        st_idle,
        st_store_wait,
        st_halt,
        st_error
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   accept;

    assign commit_ready = (state == st_idle);
    assign accept       = commit_valid && commit_ready;

    // ebreak wins over everything else in the request
    assign gpr_wen     = accept && commit.wen && !commit.is_store && !commit.is_ebreak;
    assign gpr_waddr   = commit.rd;
    assign gpr_wdata   = fmt_wdata;
    assign store_start = accept && commit.is_store && !commit.is_ebreak;

    assign watch_en = (state == st_store_wait);
    assign abort    = watch_en && timeout && !store_done;
    assign halted   = (state == st_halt) || (state == st_error);
    assign bus_err  = (state == st_error);

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (accept && commit.is_ebreak) begin
                    state_nxt = st_halt;
                end else if (store_start) begin
                    state_nxt = st_store_wait;
                end
            end
            st_store_wait: begin
                if (store_done) begin // good response beats a same-cycle timeout
                    state_nxt = st_idle;
                end else if (store_err || timeout) begin
                    state_nxt = st_error;
                end
            end
            default: begin
                state_nxt = state; // halt and error are terminal
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // store request, held for the bus master until the next store
    always_ff @(posedge clk) begin
        if (store_start) begin
            store_addr <= base_val[axil_pkg::axil_addr_w-1:0]
                        + axil_pkg::axil_addr_w'(signed'(commit.imm));
            store_data <= (commit.src_sel == rv_core_pkg::src_mem) ? commit.mem_res
                                                                   : commit.ex_res;
            store_strb <= commit.wmask;
        end
    end

    halt_is_final: assert property (
        @(posedge clk) disable iff (!rst_n)
        halted |=> halted && !commit_ready
    );

    store_blocks_port: assert property (
        @(posedge clk) disable iff (!rst_n)
        store_start |=> !commit_ready && watch_en
    );

endmodule

/* source/wb_subsystem.sv */
`timescale 1ns/1ns

module wb_subsystem #(
    parameter int TIMEOUT_CYCLES = 64
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               commit_valid,
    output logic                               commit_ready,
    input  rv_core_pkg::commit_req_t           commit,
    output logic                               aw_valid,
    output axil_pkg::axil_aw_t                 aw,
    input  logic                               aw_ready,
    output logic                               w_valid,
    output axil_pkg::axil_w_t                  w,
    input  logic                               w_ready,
    input  logic                               b_valid,
    input  axil_pkg::axil_b_t                  b,
    output logic                               b_ready,
    output logic                               halted,
    output logic                               bus_err,
    input  logic [rv_core_pkg::reg_addr_w-1:0] dbg_raddr,
    output logic [rv_core_pkg::xlen-1:0]       dbg_rdata
);

    logic [rv_core_pkg::xlen-1:0]       base_val;
    logic [rv_core_pkg::xlen-1:0]       fmt_wdata;
    logic                               gpr_wen;
    logic [rv_core_pkg::reg_addr_w-1:0] gpr_waddr;
    logic [rv_core_pkg::xlen-1:0]       gpr_wdata;
    logic                               store_start;
    logic [axil_pkg::axil_addr_w-1:0]   store_addr;
    logic [axil_pkg::axil_data_w-1:0]   store_data;
    logic [axil_pkg::axil_strb_w-1:0]   store_strb;
    logic                               store_done;
    logic                               store_err;
    logic                               watch_en;
    logic                               timeout;
    logic                               abort;

    wb_result_format wb_result_format_i (
        .res_in (commit),
        .wdata  (fmt_wdata)
    );

    gpr_file gpr_file_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wen     (gpr_wen),
        .waddr   (gpr_waddr),
        .wdata   (gpr_wdata),
        .raddr_a (commit.rs1), // store base
        .rdata_a (base_val),
        .raddr_b (dbg_raddr),
        .rdata_b (dbg_rdata)
    );

    commit_fsm commit_fsm_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready),
        .base_val     (base_val),
        .fmt_wdata    (fmt_wdata),
        .gpr_wen      (gpr_wen),
        .gpr_waddr    (gpr_waddr),
        .gpr_wdata    (gpr_wdata),
        .store_start  (store_start),
        .store_addr   (store_addr),
        .store_data   (store_data),
        .store_strb   (store_strb),
        .store_done   (store_done),
        .store_err    (store_err),
        .watch_en     (watch_en),
        .timeout      (timeout),
        .abort        (abort),
        .halted       (halted),
        .bus_err      (bus_err)
    );

    store_axil_master store_axil_master_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .store_start (store_start),
        .store_addr  (store_addr),
        .store_data  (store_data),
        .store_strb  (store_strb),
        .aw_valid    (aw_valid),
        .aw          (aw),
        .aw_ready    (aw_ready),
        .w_valid     (w_valid),
        .w           (w),
        .w_ready     (w_ready),
        .b_valid     (b_valid),
        .b           (b),
        .b_ready     (b_ready),
        .store_done  (store_done),
        .store_err   (store_err),
        .abort       (abort)
    );

    bus_watchdog #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) bus_watchdog_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .watch_en (watch_en),
        .timeout  (timeout)
    );

endmodule

/* testbench/tb_wb_subsystem.sv */
`timescale 1ns/1ns

module tb_wb_subsystem;

    localparam int mode_okay   = 0;
    localparam int mode_slverr = 1;
    localparam int mode_silent = 2; // slave never answers on b

    logic                     clk;
    logic                     rst_n;
    logic                     commit_valid;
    logic                     commit_ready;
    rv_core_pkg::commit_req_t commit;
    logic                     aw_valid;
    axil_pkg::axil_aw_t       aw;
    logic                     aw_ready;
    logic                     w_valid;
    axil_pkg::axil_w_t        w;
    logic                     w_ready;
    logic                     b_valid;
    axil_pkg::axil_b_t        b;
    logic                     b_ready;
    logic                     halted;
    logic                     bus_err;
    logic [4:0]               dbg_raddr;
    logic [63:0]              dbg_rdata;

    logic [31:0] lfsr_state;  // operands
    logic [31:0] delay_lfsr;  // slave ready delays
    string       test_name;
    int          slave_mode;
    logic        active;
    logic        aw_done;
    logic        w_done;
    logic        b_sent;
    int          aw_wait;
    int          w_wait;
    int          b_wait;
    logic [31:0] cur_addr;
    logic [2:0]  cur_prot;
    logic [63:0] cur_data;
    logic [7:0]  cur_strb;
    logic [31:0] wr_addr_q[$];
    logic [2:0]  wr_prot_q[$];
    logic [63:0] wr_data_q[$];
    logic [7:0]  wr_strb_q[$];

    wb_subsystem #(
        .TIMEOUT_CYCLES (64)
    ) wb_subsystem_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [63:0] rand_bits(inout logic [31:0] state, input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], state[0]};
            state = (state >> 1) ^ (state[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    // register value as the width and extension rule defines it
    function automatic logic [63:0] formatted(input logic [63:0] v,
                                              input rv_core_pkg::ext_kind_e kind);
        logic signed [31:0] word;
        logic signed [15:0] half;
        word = v[31:0];
        half = v[15:0];
        case (kind)
            rv_core_pkg::ext_word_s: return 64'(word);
            rv_core_pkg::ext_word_z: return {32'h0, v[31:0]};
            rv_core_pkg::ext_half_s: return 64'(half);
            default:                 return v;
        endcase
    endfunction

    function automatic rv_core_pkg::commit_req_t reg_write(input logic [4:0] rd,
                                                           input logic [63:0] value);
        rv_core_pkg::commit_req_t req;
        req = '0; // src_ex, ext_full
        req.rd = rd;
        req.wen = 1'b1;
        req.ex_res = value;
        return req;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_values(input string what, input logic [63:0] expected,
                                  input logic [63:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("Mismatch in %s, %s: expected %h, actual %h",
                                     test_name, what, expected, actual));
        end
    endtask

    // axi4-lite slave that decides each ready for the coming rising edge
    initial begin
        aw_ready = 1'b0;
        w_ready = 1'b0;
        b_valid = 1'b0;
        b = '0;
        active = 1'b0;
        b_sent = 1'b0;
        delay_lfsr = 32'h0200_b2d8;
        forever begin
            @(negedge clk);
            aw_ready = 1'b0;
            w_ready = 1'b0;
            if (!rst_n) begin
                b_valid = 1'b0;
                active = 1'b0;
                b_sent = 1'b0;
                wr_addr_q.delete();
                wr_prot_q.delete();
                wr_data_q.delete();
                wr_strb_q.delete();
            end else begin
                if (b_ready && !(active && aw_done && w_done)) begin
                    report_failure($sformatf("%s: b_ready high while no response is awaited",
                                             test_name));
                end
                if (b_sent) begin
                    b_valid = 1'b0;
                    b_sent = 1'b0;
                    active = 1'b0;
                end else if (active && aw_done && w_done && slave_mode != mode_silent) begin
                    if (b_wait > 0) begin
                        b_wait--;
                    end else begin
                        b_valid = 1'b1;
                        b.bresp = (slave_mode == mode_slverr) ? axil_pkg::resp_slverr
                                                              : axil_pkg::resp_okay;
                        if (b_ready) begin // handshake on the next edge
                            b_sent = 1'b1;
                            wr_addr_q.push_back(cur_addr);
                            wr_prot_q.push_back(cur_prot);
                            wr_data_q.push_back(cur_data);
                            wr_strb_q.push_back(cur_strb);
                        end
                    end
                end
                if (!active && aw_valid) begin
                    active = 1'b1;
                    aw_done = 1'b0;
                    w_done = 1'b0;
                    aw_wait = 1 + int'(rand_bits(delay_lfsr, 2));
                    w_wait = 1 + int'(rand_bits(delay_lfsr, 2));
                    b_wait = int'(rand_bits(delay_lfsr, 2));
                end
                if (active && aw_valid && !aw_done) begin
                    if (aw_wait > 0) begin
                        aw_wait--;
                    end else begin
                        aw_ready = 1'b1;
                        aw_done = 1'b1;
                        cur_addr = aw.awaddr;
                        cur_prot = aw.awprot;
                    end
                end
                if (active && w_valid && !w_done) begin
                    if (w_wait > 0) begin
                        w_wait--;
                    end else begin
                        w_ready = 1'b1;
                        w_done = 1'b1;
                        cur_data = w.wdata;
                        cur_strb = w.wstrb;
                    end
                end
            end
        end
    end

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        commit_valid = 1'b0;
        commit = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // returns on the falling edge after the accepting rising edge
    task automatic send_commit(input rv_core_pkg::commit_req_t req);
        int n;
        @(negedge clk);
        commit = req;
        commit_valid = 1'b1;
        n = 0;
        while (!commit_ready) begin
            if (n == 100) begin
                report_failure($sformatf("%s: commit not accepted in 100 cycles", test_name));
            end
            @(negedge clk);
            n++;
        end
        @(negedge clk);
        commit_valid = 1'b0;
    endtask

    task automatic read_reg(input logic [4:0] idx, output logic [63:0] value);
        @(negedge clk);
        dbg_raddr = idx;
        #1;
        value = dbg_rdata;
    endtask

    task automatic wait_for_ready(input int limit);
        int n;
        n = 0;
        while (!commit_ready) begin
            if (n == limit) begin
                report_failure($sformatf("%s: commit_ready stayed low for %0d cycles",
                                         test_name, limit));
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_for_bus_err(input int limit, output int cycles);
        cycles = 0;
        while (!bus_err) begin
            if (cycles == limit) begin
                report_failure($sformatf("%s: bus_err did not rise within %0d cycles",
                                         test_name, limit));
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic test_reset();
        logic [63:0] value;
        test_name = "reset";
        slave_mode = mode_okay;
        apply_reset();
        compare_values("commit_ready", 64'd1, 64'(commit_ready));
        compare_values("halted", 64'd0, 64'(halted));
        compare_values("bus_err", 64'd0, 64'(bus_err));
        compare_values("aw_valid", 64'd0, 64'(aw_valid));
        compare_values("w_valid", 64'd0, 64'(w_valid));
        compare_values("b_ready", 64'd0, 64'(b_ready));
        for (int i = 0; i < 32; i += 5) begin
            read_reg(5'(i), value);
            compare_values($sformatf("x%0d", i), 64'd0, value);
        end
    endtask

    task automatic test_reg_writes();
        rv_core_pkg::commit_req_t req;
        logic [63:0] value;
        logic [63:0] expected;
        test_name = "reg_writes";
        slave_mode = mode_okay;
        apply_reset();
        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < 8; k++) begin // each kind twice
                req = '0;
                req.wen = 1'b1;
                req.rd = 5'(1 + rand_bits(lfsr_state, 5) % 31);
                req.src_sel = rv_core_pkg::src_sel_e'(1'(s));
                req.ext_kind = rv_core_pkg::ext_kind_e'(2'(k));
                req.ex_res = rand_bits(lfsr_state, 64);
                req.mem_res = rand_bits(lfsr_state, 64);
                expected = formatted(s == 1 ? req.mem_res : req.ex_res, req.ext_kind);
                send_commit(req);
                compare_values("commit_ready after write", 64'd1, 64'(commit_ready));
                read_reg(req.rd, value);
                compare_values($sformatf("x%0d src %0d kind %0d", req.rd, s, k % 4),
                               expected, value);
            end
        end
        send_commit(reg_write(5'd0, rand_bits(lfsr_state, 64) | 64'h1));
        read_reg(5'd0, value);
        compare_values("x0", 64'd0, value);
    endtask

    task automatic test_store();
        rv_core_pkg::commit_req_t req;
        logic signed [11:0] offset;
        logic [63:0] base;
        logic [31:0] exp_addr;
        logic [63:0] exp_data;
        logic [63:0] value;
        test_name = "store";
        slave_mode = mode_okay;
        apply_reset();
        for (int t = 0; t < 3; t++) begin
            base = rand_bits(lfsr_state, 64);
            send_commit(reg_write(5'd5, base));
            offset = 12'(rand_bits(lfsr_state, 12));
            req = '0;
            req.is_store = 1'b1;
            req.rs1 = 5'd5;
            req.imm = 32'(offset);
            req.src_sel = rv_core_pkg::src_sel_e'(1'(rand_bits(lfsr_state, 1)));
            req.ext_kind = rv_core_pkg::ext_kind_e'(2'(rand_bits(lfsr_state, 2)));
            req.ex_res = rand_bits(lfsr_state, 64);
            req.mem_res = rand_bits(lfsr_state, 64);
            req.wmask = 8'(rand_bits(lfsr_state, 8));
            exp_addr = base[31:0] + req.imm;
            exp_data = (req.src_sel == rv_core_pkg::src_mem) ? req.mem_res : req.ex_res;
            send_commit(req);
            compare_values("commit_ready during store", 64'd0, 64'(commit_ready));
            wait_for_ready(100);
            compare_values("writes seen", 64'(t + 1), 64'(wr_addr_q.size()));
            compare_values("awaddr", 64'(exp_addr), 64'(wr_addr_q[t]));
            compare_values("awprot", 64'd0, 64'(wr_prot_q[t])); // unprivileged secure data
            compare_values("wdata", exp_data, wr_data_q[t]);
            compare_values("wstrb", 64'(req.wmask), 64'(wr_strb_q[t]));
        end
        send_commit(reg_write(5'd7, 64'h0123_4567_89ab_cdef));
        read_reg(5'd7, value);
        compare_values("x7 after stores", 64'h0123_4567_89ab_cdef, value);
        compare_values("bus_err after stores", 64'd0, 64'(bus_err));
    endtask

    task automatic test_slverr();
        rv_core_pkg::commit_req_t req;
        int cycles;
        test_name = "slverr";
        slave_mode = mode_slverr;
        apply_reset();
        req = '0;
        req.is_store = 1'b1;
        req.wmask = 8'hff;
        req.ex_res = rand_bits(lfsr_state, 64);
        send_commit(req);
        wait_for_bus_err(20, cycles); // well before the watchdog could fire
        for (int i = 0; i < 10; i++) begin
            compare_values("halted", 64'd1, 64'(halted));
            compare_values("bus_err", 64'd1, 64'(bus_err));
            compare_values("commit_ready", 64'd0, 64'(commit_ready));
            @(negedge clk);
        end
    endtask

    task automatic test_timeout();
        rv_core_pkg::commit_req_t req;
        int cycles;
        test_name = "timeout";
        slave_mode = mode_silent;
        apply_reset();
        req = '0;
        req.is_store = 1'b1;
        req.wmask = 8'h0f;
        send_commit(req);
        wait_for_bus_err(200, cycles);
        if (cycles < 64) begin
            report_failure($sformatf("%s: bus_err rose after only %0d cycles",
                                     test_name, cycles));
        end
        compare_values("halted", 64'd1, 64'(halted));
    endtask

    task automatic test_ebreak();
        rv_core_pkg::commit_req_t req;
        logic [63:0] keep;
        logic [63:0] value;
        test_name = "ebreak";
        slave_mode = mode_okay;
        apply_reset();
        keep = rand_bits(lfsr_state, 64);
        send_commit(reg_write(5'd3, keep));
        req = reg_write(5'd3, ~keep);
        req.is_ebreak = 1'b1; // carries a write that must not land
        send_commit(req);
        compare_values("halted", 64'd1, 64'(halted));
        @(negedge clk);
        commit = reg_write(5'd3, ~keep);
        commit_valid = 1'b1;
        for (int i = 0; i < 20; i++) begin
            compare_values("commit_ready while halted", 64'd0, 64'(commit_ready));
            @(negedge clk);
        end
        commit_valid = 1'b0;
        read_reg(5'd3, value);
        compare_values("x3 after ebreak", keep, value);
    endtask

    initial begin
        lfsr_state = 32'h0200_b2d8;
        rst_n = 1'b0;
        commit_valid = 1'b0;
        commit = '0;
        dbg_raddr = '0;
        slave_mode = mode_okay;
        test_name = "init";
        test_reset();
        test_reg_writes();
        test_store();
        test_slverr();
        test_timeout();
        test_ebreak();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* flist.f */
source/rv_core_pkg.sv
source/axil_pkg.sv
source/wb_result_format.sv
source/gpr_file.sv
source/store_axil_master.sv
source/bus_watchdog.sv
source/commit_fsm.sv
source/wb_subsystem.sv
testbench/tb_wb_subsystem.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --assert --top-module tb_wb_subsystem -Mdir obj_dir -f flist.f
	./obj_dir/Vtb_wb_subsystem

clean:
	rm -rf obj_dir
